// ==== design/mixer_pkg.sv ====
package mixer_pkg;

    localparam int NUM_LANES = 4;            // mixing lanes
    localparam int WORD_W    = 32;           // payload width
    localparam int TAG_W     = 8;            // tag width

    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [WORD_W-1:0] word_t;

    // one input item, tag in the upper bits
    typedef struct packed {
        tag_t  tag;
        word_t payload;
    } item_t;

    typedef word_t [NUM_LANES-1:0] lane_words_t;   // lane i at index i

    typedef struct packed {
        tag_t        tag;
        lane_words_t lanes;
    } result_t;

    // rotate-left amount per lane
    localparam int LANE_ROT [NUM_LANES] = '{
        0,
        7,
        13,
        24
    };

    // xor key per lane, applied after the rotation
    localparam word_t LANE_KEY [NUM_LANES] = '{
        32'h0000_0000,
        32'h9e37_79b9,
        32'h5bd1_e995,
        32'hc2b2_ae35
    };

endpackage

// ==== design/rv_splitter.sv ====
`timescale 1ns/1ps

module rv_splitter #(
    parameter type left_t  = logic,
    parameter type right_t = logic
) (
    input  logic clk,
    input  logic rst_n,

    input  logic [$bits(left_t)+$bits(right_t)-1:0] in_data,   // left in the upper bits
    input  logic   in_valid,
    output logic   in_ready,

    output left_t  left_data,
    output logic   left_valid,
    input  logic   left_ready,

    output right_t right_data,
    output logic   right_valid,
    input  logic   right_ready
);

    logic [1:0] side_ready;       // bit 0 left, bit 1 right
    logic [1:0] seen;
    logic [1:0] seen_nxt;

    assign side_ready = {right_ready, left_ready};

    // done once every side has taken the item, now or earlier
    assign in_ready = &(seen | side_ready);

    always_comb begin
        seen_nxt = seen;
        if (in_valid && in_ready) begin
            seen_nxt = '0;                    // item fully delivered
        end else if (in_valid) begin
            seen_nxt = seen | side_ready;     // remember partial takes
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seen <= '0;
        end else begin
            seen <= seen_nxt;
        end
    end

    assign left_data   = left_t'(in_data[$bits(left_t)+$bits(right_t)-1:$bits(right_t)]);
    assign left_valid  = in_valid && !seen[0];
    assign right_data  = right_t'(in_data[$bits(right_t)-1:0]);
    assign right_valid = in_valid && !seen[1];

endmodule

// ==== design/rv_duplicator.sv ====
`timescale 1ns/1ps

module rv_duplicator
    import mixer_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,

    input  word_t                in_data,
    input  logic                 in_valid,
    output logic                 in_ready,

    output word_t                out_data,     // shared by all lanes
    output logic [NUM_LANES-1:0] out_valid,
    input  logic [NUM_LANES-1:0] out_ready
);

    logic [NUM_LANES-1:0] seen;
    logic [NUM_LANES-1:0] seen_nxt;

    // a lane that already took the word no longer holds back the input
    assign in_ready = &(seen | out_ready);

    always_comb begin
        seen_nxt = seen;
        if (in_valid && in_ready) begin
            seen_nxt = '0;
        end else if (in_valid) begin
            seen_nxt = seen | out_ready;     // early takers
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seen <= '0;
        end else begin
            seen <= seen_nxt;
        end
    end

    assign out_data = in_data;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            out_valid[i] = in_valid && !seen[i];   // masked once taken
        end
    end

endmodule

// ==== design/rv_slice.sv ====
`timescale 1ns/1ps

module rv_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,

    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,

    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t data_q;       // held entry
    logic     valid_q;
    logic     load;

    // accept when empty or when the entry leaves this cycle
    assign in_ready = !valid_q || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (out_ready) begin
            valid_q <= 1'b0;          // drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= in_data;
        end
    end

    assign out_data  = data_q;
    assign out_valid = valid_q;

endmodule

// ==== design/mix_lane.sv ====
`timescale 1ns/1ps

module mix_lane
    import mixer_pkg::*;
#(
    parameter int LANE = 0
) (
    input  logic  clk,
    input  logic  rst_n,

    input  word_t in_word,
    input  logic  in_valid,
    output logic  in_ready,

    output word_t out_word,
    output logic  out_valid,
    input  logic  out_ready
);

    localparam int    ROT = LANE_ROT[LANE];
    localparam word_t KEY = LANE_KEY[LANE];

    word_t rot_word;
    word_t mix_word;
    word_t word_q;
    logic  valid_q;
    logic  load;

    // rotate left, a zero amount leaves the word as is
    assign rot_word = (in_word << ROT) | (in_word >> (WORD_W - ROT));
    assign mix_word = rot_word ^ KEY;

    assign in_ready = !valid_q || out_ready;   // same rule as rv_slice
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (out_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            word_q <= mix_word;
        end
    end

    assign out_word  = word_q;
    assign out_valid = valid_q;

endmodule

// ==== design/rv_joiner.sv ====
`timescale 1ns/1ps

module rv_joiner
    import mixer_pkg::*;
(
    input  tag_t                 tag,
    input  logic                 tag_valid,
    output logic                 tag_ready,

    input  lane_words_t          lane_word,
    input  logic [NUM_LANES-1:0] lane_valid,
    output logic [NUM_LANES-1:0] lane_ready,

    output result_t              out_data,
    output logic                 out_valid,
    input  logic                 out_ready
);

    logic all_lanes;     // every lane holds a word

    assign all_lanes = &lane_valid;

    assign out_valid = tag_valid && all_lanes;

    assign out_data.tag   = tag;
    assign out_data.lanes = lane_word;

    // tag leaves together with the lanes
    assign tag_ready = out_ready && all_lanes;

    // each lane waits for the tag and the other lanes
    always_comb begin
        logic [NUM_LANES-1:0] others;
        for (int i = 0; i < NUM_LANES; i++) begin
            others        = lane_valid;
            others[i]     = 1'b1;
            lane_ready[i] = out_ready && tag_valid && (&others);
        end
    end

endmodule

// ==== design/stream_mixer_top.sv ====
`timescale 1ns/1ps

module stream_mixer_top
    import mixer_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    input  item_t   in_item,
    input  logic    in_valid,
    output logic    in_ready,

    output result_t out_result,
    output logic    out_valid,
    input  logic    out_ready
);

    tag_t                 split_tag;        // splitter to tag slice
    logic                 split_tag_valid;
    logic                 split_tag_ready;

    word_t                split_word;       // splitter to duplicator
    logic                 split_word_valid;
    logic                 split_word_ready;

    word_t                lane_in_word;
    logic [NUM_LANES-1:0] lane_in_valid;
    logic [NUM_LANES-1:0] lane_in_ready;

    lane_words_t          lane_word;
    logic [NUM_LANES-1:0] lane_valid;
    logic [NUM_LANES-1:0] lane_ready;

    tag_t                 tag_q;
    logic                 tag_q_valid;
    logic                 tag_q_ready;

    result_t              join_data;
    logic                 join_valid;
    logic                 join_ready;

    rv_splitter #(
        .left_t  (tag_t),
        .right_t (word_t)
    ) u_splitter (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_data     (in_item),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .left_data   (split_tag),
        .left_valid  (split_tag_valid),
        .left_ready  (split_tag_ready),
        .right_data  (split_word),
        .right_valid (split_word_valid),
        .right_ready (split_word_ready)
    );

    rv_duplicator u_duplicator (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (split_word),
        .in_valid  (split_word_valid),
        .in_ready  (split_word_ready),
        .out_data  (lane_in_word),
        .out_valid (lane_in_valid),
        .out_ready (lane_in_ready)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        mix_lane #(
            .LANE (i)
        ) u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_word   (lane_in_word),
            .in_valid  (lane_in_valid[i]),
            .in_ready  (lane_in_ready[i]),
            .out_word  (lane_word[i]),
            .out_valid (lane_valid[i]),
            .out_ready (lane_ready[i])
        );
    end

    // tag path, matches the lane register stage
    rv_slice #(
        .payload_t (tag_t)
    ) u_tag_slice (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (split_tag),
        .in_valid  (split_tag_valid),
        .in_ready  (split_tag_ready),
        .out_data  (tag_q),
        .out_valid (tag_q_valid),
        .out_ready (tag_q_ready)
    );

    rv_joiner u_joiner (
        .tag        (tag_q),
        .tag_valid  (tag_q_valid),
        .tag_ready  (tag_q_ready),
        .lane_word  (lane_word),
        .lane_valid (lane_valid),
        .lane_ready (lane_ready),
        .out_data   (join_data),
        .out_valid  (join_valid),
        .out_ready  (join_ready)
    );

    rv_slice #(
        .payload_t (result_t)
    ) u_out_slice (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (join_data),
        .in_valid  (join_valid),
        .in_ready  (join_ready),
        .out_data  (out_result),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// ==== testbench/stream_mixer_properties.sv ====
`timescale 1ns/1ps

module stream_mixer_properties
    import mixer_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input item_t   in_item,
    input logic    in_valid,
    input logic    in_ready,
    input result_t out_result,
    input logic    out_valid,
    input logic    out_ready
);

    int   err_count = 0;     // failed assertions so far
    logic any_accepted;      // set by the first input transfer

    // bit b of the word lands at bit b + amount, wrapping around
    function automatic word_t rotl(input word_t w, input int amount);
        word_t r;
        for (int b = 0; b < WORD_W; b++) begin
            r[(b + amount) % WORD_W] = w[b];
        end
        return r;
    endfunction

    function automatic result_t mixed(input item_t item);
        result_t r;
        r.tag = item.tag;
        for (int i = 0; i < NUM_LANES; i++) begin
            r.lanes[i] = rotl(item.payload, LANE_ROT[i]) ^ LANE_KEY[i];
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            any_accepted <= 1'b0;
        end else if (in_valid && in_ready) begin
            any_accepted <= 1'b1;
        end
    end

    // nothing can come out before something went in
    a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !any_accepted |-> !out_valid)
        else begin
            err_count++;
            $error("out_valid high before any input was accepted");
        end

    // two cycle latency with the output draining, checked against the mixing rule
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(in_valid && in_ready, 2) && $past(out_ready) && out_ready
        |-> out_valid && (out_result == mixed($past(in_item, 2))))
        else begin
            err_count++;
            $error("result missing or wrong two cycles after an input transfer");
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_result))
        else begin
            err_count++;
            $error("output changed while stalled by out_ready");
        end

    // no stall at the input while the output drains freely
    a_throughput: assert property (@(posedge clk) disable iff (!rst_n)
        out_ready && $past(out_ready) |-> in_ready)
        else begin
            err_count++;
            $error("in_ready low while out_ready held high");
        end

endmodule

// ==== testbench/stream_mixer_tb.sv ====
`timescale 1ns/1ps

module stream_mixer_tb
    import mixer_pkg::*;
();

    localparam int NUM_ITEMS      = 300;
    localparam int FINAL_ITEMS    = 40;
    localparam int TOTAL          = NUM_ITEMS + FINAL_ITEMS;
    localparam int TIMEOUT_CYCLES = TOTAL * 4 + 100;

    logic    clk = 1'b0;
    logic    rst_n;
    item_t   in_item;
    logic    in_valid;
    logic    in_ready;
    result_t out_result;
    logic    out_valid;
    logic    out_ready;

    int      seed = 35;
    bit      hold_ready = 1'b0;    // final phase, output always drains
    int      received = 0;
    result_t expected_q [$];
    item_t   items [TOTAL];
    int      gaps [NUM_ITEMS];

    stream_mixer_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_item    (in_item),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_result (out_result),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    bind stream_mixer_top stream_mixer_properties props0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_item    (in_item),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_result (out_result),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    function automatic word_t rotate_left(input word_t w, input int amount);
        logic [2*WORD_W-1:0] dbl;
        dbl = {w, w} << amount;          // upper half holds the rotated word
        return dbl[2*WORD_W-1:WORD_W];
    endfunction

    function automatic result_t expected_result(input item_t item);
        result_t r;
        r.tag = item.tag;
        for (int i = 0; i < NUM_LANES; i++) begin
            r.lanes[i] = rotate_left(item.payload, LANE_ROT[i]) ^ LANE_KEY[i];
        end
        return r;
    endfunction

    // drive one item after some idle cycles, return once it is taken
    task automatic send_item(input item_t item, input int gap);
        if (gap > 0) begin
            @(posedge clk);
            in_valid <= 1'b0;
            repeat (gap - 1) @(posedge clk);
        end
        @(posedge clk);
        in_item  <= item;
        in_valid <= 1'b1;
        @(negedge clk);
        while (!in_ready) @(negedge clk);   // transfer on the next rising edge
    endtask

    // random back-pressure
    initial begin
        out_ready <= 1'b0;
        forever begin
            @(posedge clk);
            if (hold_ready) begin
                out_ready <= 1'b1;
            end else begin
                out_ready <= ($random(seed) % 3) != 0;
            end
        end
    end

    // scoreboard, sampled mid-cycle where handshakes are settled
    always @(negedge clk) begin
        result_t want;
        if (rst_n && in_valid && in_ready) begin
            expected_q.push_back(expected_result(in_item));
        end
        if (rst_n && out_valid && out_ready) begin
            received++;
            if (expected_q.size() == 0) begin
                abort_run("Output transfer seen with no accepted input pending");
            end else begin
                want = expected_q.pop_front();
                assert (out_result == want) else
                    abort_run($sformatf("Fail at %0t: result mismatch, expected %h, actual %h",
                                        $time, want, out_result));
            end
        end
    end

    always @(negedge clk) begin
        if (dut0.props0.err_count != 0) begin
            abort_run("A bound assertion on the DUT ports failed");
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        abort_run("Timeout: not all results arrived before the watchdog expired");
    end

    initial begin
        logic [31:0] rnd;
        for (int i = 0; i < TOTAL; i++) begin
            rnd = $random(seed);
            items[i].tag = rnd[TAG_W-1:0];
            rnd = $random(seed);
            items[i].payload = rnd;
        end
        for (int i = 0; i < NUM_ITEMS; i++) begin
            rnd = $random(seed);
            gaps[i] = (rnd[1:0] == 2'b00) ? int'(rnd[3:2]) : 0;   // mostly back to back
        end

        rst_n    <= 1'b0;
        in_valid <= 1'b0;
        in_item  <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < NUM_ITEMS; i++) begin
            send_item(items[i], gaps[i]);
        end

        hold_ready = 1'b1;
        for (int i = NUM_ITEMS; i < TOTAL; i++) begin
            send_item(items[i], 0);
        end
        @(posedge clk);
        in_valid <= 1'b0;

        while (received < TOTAL) @(negedge clk);
        repeat (10) @(negedge clk);          // catch any extra output

        if (expected_q.size() == 0 && received == TOTAL && dut0.props0.err_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            abort_run($sformatf("End of run: %0d results received, %0d still expected",
                                received, expected_q.size()));
        end
    end

endmodule

// ==== verilog.f ====
design/mixer_pkg.sv
design/rv_splitter.sv
design/rv_duplicator.sv
design/rv_slice.sv
design/mix_lane.sv
design/rv_joiner.sv
design/stream_mixer_top.sv
testbench/stream_mixer_properties.sv
testbench/stream_mixer_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the stream mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module stream_mixer_tb \
    -f verilog.f \
    -o sim_stream_mixer \
    && ./obj_dir/sim_stream_mixer | tee /dev/stderr | grep -q "TEST PASSED" \
    && echo "simulation run ok" \
    || { echo "simulation run failed"; exit 1; }
